// File: hdl/usbd_pkg.sv
package usbd_pkg;

    // ------------------------------------------------------------
    // widths and plain vector types
    // ------------------------------------------------------------
    localparam int ADDR_W = 12;

    typedef logic [ADDR_W-1:0] haddr_t;
    typedef logic [31:0]       word_t;
    typedef logic [3:0]        strobe_t;
    typedef logic [7:0]        byte_t;
    typedef logic [10:0]       ram_addr_t;  // 2 KiB descriptor space
    typedef logic [11:0]       cnt_t;
    typedef logic [3:0]        endpt_t;

    // ------------------------------------------------------------
    // address map
    // ------------------------------------------------------------
    localparam haddr_t SR_ADDR       = 12'h000;
    localparam haddr_t CR_ADDR       = 12'h004;
    localparam haddr_t RX_FLAG_ADDR  = 12'h008;
    localparam haddr_t TX_FLAG_ADDR  = 12'h00C;
    localparam haddr_t EP0_FIFO_ADDR = 12'h010;
    localparam haddr_t EP0_NUM_ADDR  = 12'h050;
    localparam haddr_t DESC_TAB_BASE = 12'h100;  // one 256-byte page
    localparam haddr_t DESC_RAM_BASE = 12'h800;  // bit 11 selects the ram

    localparam int DESC_TAB_ENTRIES = 11;
    localparam int EP0_FIFO_DEPTH   = 64;

    // control register bits, sticky flags reuse 29..31 in SR
    localparam int CR_EN_BIT        = 0;
    localparam int CR_SEND_Z_BIT    = 1;
    localparam int CR_SETUP_IE_BIT  = 29;
    localparam int CR_EPIN_IE_BIT   = 30;
    localparam int CR_EPOUT_IE_BIT  = 31;

    // ------------------------------------------------------------
    // grouped signals
    // ------------------------------------------------------------
    typedef struct packed {
        haddr_t  addr;
        logic    rd;
        logic    wr;
        strobe_t strobe;
    } bus_req_t;

    typedef struct packed {
        endpt_t endpt;
        byte_t  rxdat;
        logic   rxval;
        logic   rxact;
        logic   txact;
        logic   txpop;
        logic   setup;
        logic   link_rst;
        logic   hispeed;
        logic   suspend;
        logic   online;
    } link_rx_t;

    typedef struct packed {
        byte_t txdat;
        logic  txval;
        cnt_t  txlen;
    } ep0_tx_t;

    typedef struct packed {
        logic  rx_full;
        logic  rx_empty;
        logic  tx_full;
        logic  tx_empty;
        cnt_t  rx_cnt;
        cnt_t  tx_cnt;
        byte_t rx_head;
    } ep0_stat_t;

    typedef word_t [DESC_TAB_ENTRIES-1:0] desc_table_t;

    // word-granular register match
    function automatic logic word_hit(haddr_t a, haddr_t t);
        return a[ADDR_W-1:2] == t[ADDR_W-1:2];
    endfunction

    function automatic logic ram_hit(haddr_t a);
        return (a & DESC_RAM_BASE) != '0;
    endfunction

    // byte-lane merge of a write into an existing word
    function automatic word_t merge(word_t old, word_t wdata, strobe_t stb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (stb[b])
                res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

endpackage

// File: hdl/usbd_byte_fifo.sv
`timescale 1ns/1ps

module usbd_byte_fifo #(
    parameter int DEPTH = usbd_pkg::EP0_FIFO_DEPTH
) (
    input  logic            hclk,
    input  logic            hresetn,
    input  logic            clr_i,
    input  logic            push_i,
    input  usbd_pkg::byte_t data_i,
    input  logic            pop_i,
    output usbd_pkg::byte_t head_o,
    output usbd_pkg::cnt_t  count_o,
    output logic            empty_o,
    output logic            full_o
);
    import usbd_pkg::*;

    localparam int AW = $clog2(DEPTH);

    byte_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    cnt_t          cnt_q;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i & ~full_o;   // push into full is dropped
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge hclk) begin
        if (do_push)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt_q  <= '0;
        end else if (clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt_q  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            cnt_q <= cnt_q + cnt_t'(do_push) - cnt_t'(do_pop);
        end
    end

    assign head_o  = mem[rd_ptr];  // fall-through
    assign count_o = cnt_q;
    assign empty_o = cnt_q == '0;
    assign full_o  = cnt_q == cnt_t'(DEPTH);

endmodule

// File: hdl/usbd_ahb_slave.sv
`timescale 1ns/1ps

module usbd_ahb_slave (
    input  logic              hclk,
    input  logic              hresetn,
    input  logic              hsel_i,
    input  usbd_pkg::haddr_t  haddr_i,
    input  logic [1:0]        htrans_i,
    input  logic [2:0]        hsize_i,
    input  logic              hwrite_i,
    input  logic              hready_i,
    output usbd_pkg::bus_req_t req_o
);
    import usbd_pkg::*;

    logic     trans_req;
    logic     rd_req;
    logic     wr_req;
    logic     upd_rd;
    logic     upd_wr;
    strobe_t  strobe_nxt;
    bus_req_t req_q;

    // NONSEQ or SEQ, selected, previous transfer done
    assign trans_req = hready_i & hsel_i & htrans_i[1];
    assign rd_req    = trans_req & ~hwrite_i;
    assign wr_req    = trans_req & hwrite_i;

    // new request, or end of the current data phase
    assign upd_rd = rd_req | (req_q.rd & hready_i);
    assign upd_wr = wr_req | (req_q.wr & hready_i);

    // ------------------------------------------------------------
    // byte lanes from size and low address bits
    // ------------------------------------------------------------
    always_comb begin
        case (hsize_i)
            3'b000:  strobe_nxt = strobe_t'(4'b0001 << haddr_i[1:0]);  // byte
            3'b001:  strobe_nxt = haddr_i[1] ? 4'b1100 : 4'b0011;     // halfword
            default: strobe_nxt = 4'b1111;
        endcase
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            req_q <= '0;
        end else begin
            if (trans_req)
                req_q.addr <= haddr_i;
            if (upd_rd)
                req_q.rd <= rd_req;
            if (upd_wr)
                req_q.wr <= wr_req;
            if (upd_rd | upd_wr)
                req_q.strobe <= strobe_nxt;
        end
    end

    assign req_o = req_q;  // data-phase view

endmodule

// File: hdl/usbd_regs.sv
`timescale 1ns/1ps

module usbd_regs (
    input  logic                  hclk,
    input  logic                  hresetn,
    input  usbd_pkg::bus_req_t    req_i,
    input  usbd_pkg::word_t       hwdata_i,
    input  usbd_pkg::link_rx_t    link_i,
    input  usbd_pkg::ep0_stat_t   ep0_stat_i,
    input  usbd_pkg::byte_t       ram_rdata_i,
    output usbd_pkg::word_t       hrdata_o,
    output usbd_pkg::desc_table_t desc_table_o,
    output logic                  ctrl_en_o,
    output logic                  intr_o
);
    import usbd_pkg::*;

    word_t       ctrl_q;
    desc_table_t tab_q;
    logic        tab_hit;
    logic [3:0]  tab_idx;
    logic [2:0]  src_q;     // {rxact, txact, setup}, first stage
    logic [2:0]  src_qq;
    logic [2:0]  fall;
    logic [2:0]  flags_q;   // {epout, epin, setup}
    logic [2:0]  flag_clr;
    logic [2:0]  flag_en;
    endpt_t      ep_q;

    assign tab_hit = req_i.addr[ADDR_W-1:8] == DESC_TAB_BASE[ADDR_W-1:8]
                   && req_i.addr[7:2] < DESC_TAB_ENTRIES;
    assign tab_idx = req_i.addr[5:2];

    // ------------------------------------------------------------
    // control register and descriptor table
    // ------------------------------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ctrl_q <= '0;
            tab_q  <= '0;
        end else if (req_i.wr) begin
            if (word_hit(req_i.addr, CR_ADDR))
                ctrl_q <= merge(ctrl_q, hwdata_i, req_i.strobe);
            if (tab_hit)
                tab_q[tab_idx] <= merge(tab_q[tab_idx], hwdata_i, req_i.strobe);
        end
    end

    // ------------------------------------------------------------
    // edge detect and sticky interrupt flags
    // ------------------------------------------------------------
    assign fall     = src_qq & ~src_q;
    assign flag_clr = {hwdata_i[CR_EPOUT_IE_BIT], hwdata_i[CR_EPIN_IE_BIT],
                       hwdata_i[CR_SETUP_IE_BIT]}
                    & {3{req_i.wr & word_hit(req_i.addr, SR_ADDR) & req_i.strobe[3]}};

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            src_q   <= '0;
            src_qq  <= '0;
            flags_q <= '0;
            ep_q    <= '0;
        end else if (link_i.link_rst) begin
            src_q   <= '0;
            src_qq  <= '0;
            flags_q <= '0;
            ep_q    <= '0;
        end else begin
            src_q   <= {link_i.rxact, link_i.txact, link_i.setup};
            src_qq  <= src_q;
            flags_q <= (flags_q | fall) & ~flag_clr;  // clear wins
            if (link_i.rxact && !src_q[2])
                ep_q <= link_i.endpt;  // rising rxact
        end
    end

    assign flag_en = {ctrl_q[CR_EPOUT_IE_BIT], ctrl_q[CR_EPIN_IE_BIT],
                      ctrl_q[CR_SETUP_IE_BIT]};
    assign intr_o  = |(flags_q & flag_en);

    // ------------------------------------------------------------
    // read data
    // ------------------------------------------------------------
    always_comb begin
        hrdata_o = '0;
        if (req_i.rd) begin
            if (ram_hit(req_i.addr)) begin
                hrdata_o = {4{ram_rdata_i}};
            end else if (tab_hit) begin
                hrdata_o = tab_q[tab_idx];
            end else begin
                case (req_i.addr[ADDR_W-1:2])
                    SR_ADDR[ADDR_W-1:2]:
                        hrdata_o = {flags_q, 21'd0, ep_q, src_q[0],
                                    link_i.hispeed, link_i.suspend, link_i.online};
                    CR_ADDR[ADDR_W-1:2]:
                        hrdata_o = ctrl_q;
                    RX_FLAG_ADDR[ADDR_W-1:2]:
                        hrdata_o = {15'd0, ep0_stat_i.rx_full, 15'd0, ep0_stat_i.rx_empty};
                    TX_FLAG_ADDR[ADDR_W-1:2]:
                        hrdata_o = {15'd0, ep0_stat_i.tx_full, 15'd0, ep0_stat_i.tx_empty};
                    EP0_FIFO_ADDR[ADDR_W-1:2]:
                        hrdata_o = {24'd0, ep0_stat_i.rx_head};
                    EP0_NUM_ADDR[ADDR_W-1:2]:
                        hrdata_o = {4'd0, ep0_stat_i.tx_cnt, 4'd0, ep0_stat_i.rx_cnt};
                    default:
                        hrdata_o = '0;
                endcase
            end
        end
    end

    assign desc_table_o = tab_q;
    assign ctrl_en_o    = ctrl_q[CR_EN_BIT];

endmodule

// File: hdl/usbd_ep0_path.sv
`timescale 1ns/1ps

module usbd_ep0_path (
    input  logic                hclk,
    input  logic                hresetn,
    input  usbd_pkg::bus_req_t  req_i,
    input  usbd_pkg::word_t     hwdata_i,
    input  usbd_pkg::link_rx_t  link_i,
    output usbd_pkg::ep0_tx_t   ep0_tx_o,
    output logic                link_rxrdy_o,
    output usbd_pkg::ep0_stat_t ep0_stat_o
);
    import usbd_pkg::*;

    logic  ep0_sel;
    logic  fifo_hit;
    logic  rx_push;
    logic  rx_pop;
    logic  tx_push;
    logic  tx_pop;
    byte_t tx_head;
    cnt_t  txlen_q;

    // only endpoint 0 is kept, so the endpoint mux is just a gate
    assign ep0_sel  = link_i.endpt == endpt_t'(0);
    assign fifo_hit = word_hit(req_i.addr, EP0_FIFO_ADDR);

    assign rx_push = link_i.rxval & ep0_sel;
    assign rx_pop  = req_i.rd & fifo_hit;   // read pops head in data phase
    assign tx_push = req_i.wr & fifo_hit;   // lane 0 only
    assign tx_pop  = link_i.txpop & ep0_sel;

    usbd_byte_fifo u_rx_fifo (
        .hclk    (hclk),
        .hresetn (hresetn),
        .clr_i   (link_i.link_rst),
        .push_i  (rx_push),
        .data_i  (link_i.rxdat),
        .pop_i   (rx_pop),
        .head_o  (ep0_stat_o.rx_head),
        .count_o (ep0_stat_o.rx_cnt),
        .empty_o (ep0_stat_o.rx_empty),
        .full_o  (ep0_stat_o.rx_full)
    );

    usbd_byte_fifo u_tx_fifo (
        .hclk    (hclk),
        .hresetn (hresetn),
        .clr_i   (link_i.link_rst),
        .push_i  (tx_push),
        .data_i  (hwdata_i[7:0]),
        .pop_i   (tx_pop),
        .head_o  (tx_head),
        .count_o (ep0_stat_o.tx_cnt),
        .empty_o (ep0_stat_o.tx_empty),
        .full_o  (ep0_stat_o.tx_full)
    );

    // length frozen while the link is transmitting
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn)
            txlen_q <= '0;
        else if (!link_i.txact)
            txlen_q <= ep0_stat_o.tx_cnt;
    end

    assign ep0_tx_o.txdat = tx_head;
    assign ep0_tx_o.txval = ep0_sel & ~ep0_stat_o.tx_empty;
    assign ep0_tx_o.txlen = txlen_q;
    assign link_rxrdy_o   = ~ep0_stat_o.rx_full;  // back-pressure to link

endmodule

// File: hdl/usbd_desc_ram.sv
`timescale 1ns/1ps

module usbd_desc_ram (
    input  logic                hclk,
    input  logic                hresetn,
    input  usbd_pkg::haddr_t    haddr_i,
    input  usbd_pkg::bus_req_t  req_i,
    input  usbd_pkg::word_t     hwdata_i,
    input  logic                ctrl_en_i,
    output usbd_pkg::byte_t     bus_rdata_o,
    input  usbd_pkg::ram_addr_t link_raddr_i,
    output usbd_pkg::byte_t     link_rdata_o
);
    import usbd_pkg::*;

    localparam int RAM_BYTES = 2 ** $bits(ram_addr_t);

    byte_t     mem [RAM_BYTES];
    ram_addr_t wr_addr;
    ram_addr_t rd_addr;
    byte_t     wr_byte;
    logic      bus_we;

    assign wr_addr = req_i.addr[$bits(ram_addr_t)-1:0];  // data-phase address
    assign rd_addr = haddr_i[$bits(ram_addr_t)-1:0];     // address-phase address
    assign wr_byte = hwdata_i[{req_i.addr[1:0], 3'b000} +: 8];

    // writes only while the controller is disabled
    assign bus_we = req_i.wr & ram_hit(req_i.addr) & req_i.strobe[req_i.addr[1:0]]
                  & ~ctrl_en_i;

    always_ff @(posedge hclk) begin
        if (bus_we)
            mem[wr_addr] <= wr_byte;
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            bus_rdata_o  <= '0;
            link_rdata_o <= '0;
        end else begin
            bus_rdata_o  <= (bus_we && wr_addr == rd_addr) ? wr_byte : mem[rd_addr];
            link_rdata_o <= mem[link_raddr_i];  // one cycle latency
        end
    end

endmodule

// File: hdl/usbd_ahb_top.sv
`timescale 1ns/1ps

module usbd_ahb_top (
    input  logic                  hclk,
    input  logic                  hresetn,
    // ahb-lite slave port
    input  logic                  hsel_i,
    input  usbd_pkg::haddr_t      haddr_i,
    input  logic [1:0]            htrans_i,
    input  logic [2:0]            hsize_i,
    input  logic                  hwrite_i,
    input  logic                  hready_i,
    input  usbd_pkg::word_t       hwdata_i,
    output logic                  hreadyout_o,
    output logic                  hresp_o,
    output usbd_pkg::word_t       hrdata_o,
    // link core side
    input  usbd_pkg::link_rx_t    link_i,
    output logic                  link_rxrdy_o,
    output usbd_pkg::ep0_tx_t     ep0_tx_o,
    input  usbd_pkg::ram_addr_t   desc_raddr_i,
    output usbd_pkg::byte_t       desc_rdata_o,
    output usbd_pkg::desc_table_t desc_table_o,
    output logic                  intr_o,
    output logic                  usb_nrst_o
);
    import usbd_pkg::*;

    bus_req_t  req;
    ep0_stat_t ep0_stat;
    byte_t     ram_rdata;
    logic      ctrl_en;

    usbd_ahb_slave u_slave (
        .hclk     (hclk),
        .hresetn  (hresetn),
        .hsel_i   (hsel_i),
        .haddr_i  (haddr_i),
        .htrans_i (htrans_i),
        .hsize_i  (hsize_i),
        .hwrite_i (hwrite_i),
        .hready_i (hready_i),
        .req_o    (req)
    );

    usbd_regs u_regs (
        .hclk         (hclk),
        .hresetn      (hresetn),
        .req_i        (req),
        .hwdata_i     (hwdata_i),
        .link_i       (link_i),
        .ep0_stat_i   (ep0_stat),
        .ram_rdata_i  (ram_rdata),
        .hrdata_o     (hrdata_o),
        .desc_table_o (desc_table_o),
        .ctrl_en_o    (ctrl_en),
        .intr_o       (intr_o)
    );

    usbd_ep0_path u_ep0 (
        .hclk         (hclk),
        .hresetn      (hresetn),
        .req_i        (req),
        .hwdata_i     (hwdata_i),
        .link_i       (link_i),
        .ep0_tx_o     (ep0_tx_o),
        .link_rxrdy_o (link_rxrdy_o),
        .ep0_stat_o   (ep0_stat)
    );

    usbd_desc_ram u_desc_ram (
        .hclk         (hclk),
        .hresetn      (hresetn),
        .haddr_i      (haddr_i),
        .req_i        (req),
        .hwdata_i     (hwdata_i),
        .ctrl_en_i    (ctrl_en),
        .bus_rdata_o  (ram_rdata),
        .link_raddr_i (desc_raddr_i),
        .link_rdata_o (desc_rdata_o)
    );

    assign hreadyout_o = 1'b1;  // zero wait states
    assign hresp_o     = 1'b0;  // always OKAY
    assign usb_nrst_o  = hresetn & ctrl_en;

endmodule

// File: tb/usbd_ahb_chk.sv
`timescale 1ns/1ps

module usbd_ahb_chk (
    input logic                hclk,
    input logic                hresetn,
    input logic                hreadyout_i,
    input logic                hresp_i,
    input logic                link_rxrdy_i,
    input usbd_pkg::ep0_stat_t ep0_stat_i,
    input usbd_pkg::link_rx_t  link_i,
    input usbd_pkg::ep0_tx_t   ep0_tx_i,
    input usbd_pkg::word_t     ctrl_i,
    input logic [2:0]          flags_i,   // {epout, epin, setup}
    input logic                intr_i,
    input logic                usb_nrst_i
);
    import usbd_pkg::*;

    int unsigned fail_cnt = 0;
    logic [2:0]  enables;

    assign enables = {ctrl_i[CR_EPOUT_IE_BIT], ctrl_i[CR_EPIN_IE_BIT],
                      ctrl_i[CR_SETUP_IE_BIT]};

    // ------------------------------------------------------------
    // bus side
    // ------------------------------------------------------------
    a_zero_wait: assert property (@(posedge hclk) disable iff (!hresetn)
        hreadyout_i && !hresp_i)
        else begin
            fail_cnt++;
            $error("slave stalled or returned an error response");
        end

    // ------------------------------------------------------------
    // link side
    // ------------------------------------------------------------
    a_rxrdy: assert property (@(posedge hclk) disable iff (!hresetn)
        link_rxrdy_i == !ep0_stat_i.rx_full)
        else begin
            fail_cnt++;
            $error("link_rxrdy_o does not follow the receive FIFO full flag");
        end

    a_txval: assert property (@(posedge hclk) disable iff (!hresetn)
        ep0_tx_i.txval |-> (link_i.endpt == endpt_t'(0)) && !ep0_stat_i.tx_empty)
        else begin
            fail_cnt++;
            $error("txval high without endpoint 0 or with an empty transmit FIFO");
        end

    a_intr: assert property (@(posedge hclk) disable iff (!hresetn)
        intr_i == |(flags_i & enables))
        else begin
            fail_cnt++;
            $error("intr_o differs from the enabled sticky flags");
        end

    a_nrst: assert property (@(posedge hclk) disable iff (!hresetn)
        !ctrl_i[CR_EN_BIT] |-> !usb_nrst_i)
        else begin
            fail_cnt++;
            $error("usb_nrst_o high while the controller is disabled");
        end

endmodule

bind usbd_ahb_top usbd_ahb_chk u_chk (
    .hclk         (hclk),
    .hresetn      (hresetn),
    .hreadyout_i  (hreadyout_o),
    .hresp_i      (hresp_o),
    .link_rxrdy_i (link_rxrdy_o),
    .ep0_stat_i   (ep0_stat),
    .link_i       (link_i),
    .ep0_tx_i     (ep0_tx_o),
    .ctrl_i       (u_regs.ctrl_q),
    .flags_i      (u_regs.flags_q),
    .intr_i       (intr_o),
    .usb_nrst_i   (usb_nrst_o)
);

// File: tb/tb_usbd_ahb_top.sv
`timescale 1ns/1ps

module tb_usbd_ahb_top;
    import usbd_pkg::*;

    localparam int         MAX_CYCLES    = 2000;  // about five times the test length
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [2:0] SIZE_BYTE     = 3'b000;
    localparam logic [2:0] SIZE_HALF     = 3'b001;
    localparam logic [2:0] SIZE_WORD     = 3'b010;

    logic        hclk;
    logic        hresetn;
    logic        hsel;
    haddr_t      haddr;
    logic [1:0]  htrans;
    logic [2:0]  hsize;
    logic        hwrite;
    logic        hready;
    word_t       hwdata;
    logic        hreadyout;
    logic        hresp;
    word_t       hrdata;
    link_rx_t    link;
    logic        link_rxrdy;
    ep0_tx_t     ep0_tx;
    ram_addr_t   desc_raddr;
    byte_t       desc_rdata;
    desc_table_t desc_table;
    logic        intr;
    logic        usb_nrst;

    integer      seed;
    int          err_cnt;
    int          cycle_cnt = 0;
    word_t       cr_exp;
    word_t       tab_exp [DESC_TAB_ENTRIES];
    haddr_t      ram_adr [8];
    byte_t       ram_exp [8];
    byte_t       fifo_exp [$];

    initial hclk = 1'b0;
    always #10 hclk = ~hclk;  // 20 ns period

    usbd_ahb_top UUT (
        .hclk         (hclk),
        .hresetn      (hresetn),
        .hsel_i       (hsel),
        .haddr_i      (haddr),
        .htrans_i     (htrans),
        .hsize_i      (hsize),
        .hwrite_i     (hwrite),
        .hready_i     (hready),
        .hwdata_i     (hwdata),
        .hreadyout_o  (hreadyout),
        .hresp_o      (hresp),
        .hrdata_o     (hrdata),
        .link_i       (link),
        .link_rxrdy_o (link_rxrdy),
        .ep0_tx_o     (ep0_tx),
        .desc_raddr_i (desc_raddr),
        .desc_rdata_o (desc_rdata),
        .desc_table_o (desc_table),
        .intr_o       (intr),
        .usb_nrst_o   (usb_nrst)
    );

    // watchdog
    always @(posedge hclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // bus and link helpers
    // ------------------------------------------------------------
    task automatic write_bus(input haddr_t addr, input logic [2:0] size, input word_t data);
        @(posedge hclk);
        hsel   <= 1'b1;
        haddr  <= addr;
        htrans <= HTRANS_NONSEQ;
        hwrite <= 1'b1;
        hsize  <= size;
        @(posedge hclk);  // data phase
        hsel   <= 1'b0;
        htrans <= HTRANS_IDLE;
        hwrite <= 1'b0;
        hwdata <= data;
    endtask

    task automatic read_bus(input haddr_t addr, output word_t data);
        @(posedge hclk);
        hsel   <= 1'b1;
        haddr  <= addr;
        htrans <= HTRANS_NONSEQ;
        hwrite <= 1'b0;
        hsize  <= SIZE_WORD;
        @(posedge hclk);
        hsel   <= 1'b0;
        htrans <= HTRANS_IDLE;
        @(negedge hclk);  // middle of the data phase
        data = hrdata;
    endtask

    task automatic compare(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_read(input haddr_t addr, input word_t exp, input string what);
        word_t got;
        read_bus(addr, got);
        compare(what, got, exp);
    endtask

    task automatic settle(input int n);
        repeat (n) @(posedge hclk);
        @(negedge hclk);
    endtask

    task automatic send_rx(input endpt_t ep, input byte_t b);
        @(posedge hclk);
        link.endpt <= ep;
        link.rxdat <= b;
        link.rxval <= 1'b1;
        @(posedge hclk);
        link.rxval <= 1'b0;
    endtask

    // sel is {rxact, txact, setup}, two cycles high
    task automatic pulse_event(input logic [2:0] sel, input endpt_t ep);
        @(posedge hclk);
        link.endpt <= ep;
        link.rxact <= sel[2];
        link.txact <= sel[1];
        link.setup <= sel[0];
        repeat (2) @(posedge hclk);
        link.rxact <= 1'b0;
        link.txact <= 1'b0;
        link.setup <= 1'b0;
    endtask

    initial begin
        word_t w;
        byte_t b;
        int    n;

        seed       = 32'haf536ead;
        err_cnt    = 0;
        hresetn    = 1'b0;
        hsel       = 1'b0;
        haddr      = '0;
        htrans     = HTRANS_IDLE;
        hsize      = SIZE_WORD;
        hwrite     = 1'b0;
        hready     = 1'b1;
        hwdata     = '0;
        link       = '0;
        desc_raddr = '0;
        repeat (4) @(posedge hclk);
        hresetn <= 1'b1;

        // ------------------------------------------------------------
        // reset values
        // ------------------------------------------------------------
        @(negedge hclk);
        compare("intr_o after reset", 32'(intr), 32'd0);
        compare("usb_nrst_o after reset", 32'(usb_nrst), 32'd0);
        check_read(CR_ADDR, 32'd0, "CR after reset");
        check_read(SR_ADDR, 32'd0, "SR after reset");
        check_read(EP0_NUM_ADDR, 32'd0, "EP0 counts after reset");
        check_read(RX_FLAG_ADDR, 32'd1, "RX flags after reset");
        check_read(TX_FLAG_ADDR, 32'd1, "TX flags after reset");

        // ------------------------------------------------------------
        // control register lanes
        // ------------------------------------------------------------
        write_bus(CR_ADDR + 12'd2, SIZE_BYTE, 32'h00A5_0000);
        check_read(CR_ADDR, 32'h00A5_0000, "CR after byte write to lane 2");
        write_bus(CR_ADDR, SIZE_HALF, 32'hFFFF_1234);          // upper half ignored
        write_bus(CR_ADDR + 12'd2, SIZE_HALF, 32'hC3C3_5555);  // lower half ignored
        cr_exp = {8'hC3, 8'hC3, 8'h12, 8'h34};
        check_read(CR_ADDR, cr_exp, "CR after lane writes");
        write_bus(CR_ADDR, SIZE_BYTE, 32'hEEEE_EE01);
        cr_exp[7:0] = 8'h01;
        check_read(CR_ADDR, cr_exp, "CR with enable set");
        compare("usb_nrst_o with enable set", 32'(usb_nrst), 32'd1);
        write_bus(CR_ADDR, SIZE_BYTE, 32'h0000_0000);
        settle(1);
        compare("usb_nrst_o with enable clear", 32'(usb_nrst), 32'd0);

        // ------------------------------------------------------------
        // descriptor table and descriptor RAM
        // ------------------------------------------------------------
        for (int i = 0; i < DESC_TAB_ENTRIES; i++) begin
            tab_exp[i] = $random(seed);
            write_bus(DESC_TAB_BASE + haddr_t'(4 * i), SIZE_WORD, tab_exp[i]);
        end
        for (int i = 0; i < DESC_TAB_ENTRIES; i++) begin
            check_read(DESC_TAB_BASE + haddr_t'(4 * i), tab_exp[i], "descriptor table entry");
            compare("desc_table_o entry", desc_table[i], tab_exp[i]);
        end
        for (int k = 0; k < 8; k++) begin
            ram_adr[k] = DESC_RAM_BASE + haddr_t'(k * 243);  // spread over the RAM
            ram_exp[k] = $random(seed);
            write_bus(ram_adr[k], SIZE_BYTE, {4{ram_exp[k]}});
        end
        for (int k = 0; k < 8; k++) begin
            check_read(ram_adr[k], {4{ram_exp[k]}}, "descriptor RAM byte");
            @(posedge hclk);
            desc_raddr <= ram_adr[k][10:0];
            @(posedge hclk);
            @(negedge hclk);
            compare("desc_rdata_o", 32'(desc_rdata), 32'(ram_exp[k]));
        end
        write_bus(CR_ADDR, SIZE_BYTE, 32'h0000_0001);
        write_bus(ram_adr[3], SIZE_BYTE, ~{4{ram_exp[3]}});
        write_bus(CR_ADDR, SIZE_BYTE, 32'h0000_0000);
        check_read(ram_adr[3], {4{ram_exp[3]}}, "descriptor RAM after write while enabled");

        // ------------------------------------------------------------
        // endpoint 0 transmit
        // ------------------------------------------------------------
        n = 4 + ($random(seed) & 7);
        for (int k = 0; k < n; k++) begin
            w = $random(seed);
            fifo_exp.push_back(w[7:0]);
            write_bus(EP0_FIFO_ADDR, SIZE_WORD, w);
        end
        check_read(EP0_NUM_ADDR, {4'd0, 12'(n), 16'd0}, "EP0 counts after tx writes");
        compare("txlen", 32'(ep0_tx.txlen), 32'(n));
        @(posedge hclk);
        link.endpt <= 4'd3;
        link.txpop <= 1'b1;
        repeat (3) @(posedge hclk);
        link.txpop <= 1'b0;
        @(negedge hclk);
        compare("txval on endpoint 3", 32'(ep0_tx.txval), 32'd0);
        check_read(EP0_NUM_ADDR, {4'd0, 12'(n), 16'd0}, "EP0 counts after pops on endpoint 3");
        @(posedge hclk);
        link.endpt <= '0;
        while (fifo_exp.size() > 0) begin
            @(negedge hclk);
            compare("txval", 32'(ep0_tx.txval), 32'd1);
            compare("txdat", 32'(ep0_tx.txdat), 32'(fifo_exp.pop_front()));
            @(posedge hclk);
            link.txpop <= 1'b1;
            @(posedge hclk);
            link.txpop <= 1'b0;
        end
        @(negedge hclk);
        compare("txval after draining", 32'(ep0_tx.txval), 32'd0);
        check_read(EP0_NUM_ADDR, 32'd0, "EP0 counts after tx drain");

        // ------------------------------------------------------------
        // endpoint 0 receive
        // ------------------------------------------------------------
        n = 3 + ($random(seed) & 3);
        for (int k = 0; k < n; k++) begin
            b = $random(seed);
            fifo_exp.push_back(b);
            send_rx(4'd0, b);
        end
        send_rx(4'd2, 8'hEE);  // other endpoints are not stored
        send_rx(4'd9, 8'h5A);
        check_read(EP0_NUM_ADDR, 32'(n), "EP0 counts after rx bytes");
        check_read(RX_FLAG_ADDR, 32'd0, "RX flags holding data");
        while (fifo_exp.size() > 0)
            check_read(EP0_FIFO_ADDR, 32'(fifo_exp.pop_front()), "EP0 receive byte");
        check_read(EP0_NUM_ADDR, 32'd0, "EP0 counts after rx drain");
        check_read(RX_FLAG_ADDR, 32'd1, "RX flags after rx drain");

        // ------------------------------------------------------------
        // status flags and interrupt
        // ------------------------------------------------------------
        pulse_event(3'b001, 4'd0);  // setup, its enable is clear
        settle(3);
        compare("intr_o after setup", 32'(intr), 32'd0);
        check_read(SR_ADDR, 32'h2000_0000, "SR after setup");
        pulse_event(3'b100, 4'd5);  // rxact on endpoint 5
        settle(3);
        compare("intr_o after rxact", 32'(intr), 32'd1);
        check_read(SR_ADDR, 32'hA000_0050, "SR after rxact");
        pulse_event(3'b010, 4'd0);
        settle(3);
        check_read(SR_ADDR, 32'hE000_0050, "SR after txact");
        write_bus(SR_ADDR, SIZE_HALF, 32'hFFFF_FFFF);  // byte 3 not strobed
        check_read(SR_ADDR, 32'hE000_0050, "SR after write without byte 3");
        write_bus(SR_ADDR + 12'd3, SIZE_BYTE, 32'h8000_0000);
        check_read(SR_ADDR, 32'h6000_0050, "SR after clearing EPOUT");
        compare("intr_o with EPIN pending", 32'(intr), 32'd1);
        write_bus(SR_ADDR, SIZE_WORD, 32'h6000_0000);
        check_read(SR_ADDR, 32'h0000_0050, "SR after clearing all flags");
        compare("intr_o after clearing", 32'(intr), 32'd0);

        settle(2);
        $display("checks done: %0d value errors, %0d assertion failures",
                 err_cnt, UUT.u_chk.fail_cnt);
        if (err_cnt == 0 && UUT.u_chk.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: usbd_ahb_top.f
hdl/usbd_pkg.sv
hdl/usbd_byte_fifo.sv
hdl/usbd_ahb_slave.sv
hdl/usbd_regs.sv
hdl/usbd_ep0_path.sv
hdl/usbd_desc_ram.sv
hdl/usbd_ahb_top.sv
tb/usbd_ahb_chk.sv
tb/tb_usbd_ahb_top.sv
